/* fib_config.svh */
`ifndef FIB_CONFIG_SVH
`define FIB_CONFIG_SVH

// Name prefix width in bits
`define FIB_PREFIX_W 64

// Width of a prefix length or lookup limit
`define FIB_LEN_W 6

// One bank per prefix length
`define FIB_NUM_LEN 64

// Folded hash width, indexes one bank bitmap
`define FIB_HASH_W 10

// Valid bits per bank, 2**FIB_HASH_W
`define FIB_BITMAP_DEPTH 1024

`endif

/* fib_pkg.sv */
`include "fib_config.svh"

package fib_pkg;

    // Request operation
    typedef enum logic {
        FIB_OP_INSERT = 1'b0,
        FIB_OP_LOOKUP = 1'b1
    } fib_op_e;

    // Request as it arrives at the table
    // len is the insert length or the lookup limit
    typedef struct packed {
        fib_op_e                  op;
        logic [`FIB_PREFIX_W-1:0] prefix;
        logic [`FIB_LEN_W-1:0]    len;
    } fib_req_t;

    // Decoded request broadcast to every bank
    typedef struct packed {
        logic                     lookup;
        logic [`FIB_PREFIX_W-1:0] prefix;
        logic [`FIB_LEN_W-1:0]    limit;
        logic [`FIB_NUM_LEN-1:0]  wr_en;
        logic [`FIB_NUM_LEN-1:0]  rd_en;
    } fib_bank_req_t;

    // Lookup answer, prefix already masked to len
    typedef struct packed {
        logic                     hit;
        logic [`FIB_LEN_W-1:0]    len;
        logic [`FIB_PREFIX_W-1:0] prefix;
    } fib_resp_t;

    // Keep the top len bits, clear the rest
    function automatic logic [`FIB_PREFIX_W-1:0] fib_mask(
        input logic [`FIB_PREFIX_W-1:0] prefix,
        input logic [`FIB_LEN_W-1:0]    len
    );
        logic [`FIB_PREFIX_W-1:0] ones;
        ones = '1;
        return prefix & ~(ones >> len);
    endfunction

    // XOR fold in hash-width chunks from the LSB end
    // Last chunk comes out zero padded from the shift
    function automatic logic [`FIB_HASH_W-1:0] fib_hash(
        input logic [`FIB_PREFIX_W-1:0] prefix
    );
        logic [`FIB_HASH_W-1:0]   h;
        logic [`FIB_PREFIX_W-1:0] rest;
        h    = '0;
        rest = prefix;
        for (int i = 0; i < (`FIB_PREFIX_W + `FIB_HASH_W - 1) / `FIB_HASH_W; i++) begin
            h    = h ^ rest[`FIB_HASH_W-1:0];
            rest = rest >> `FIB_HASH_W;
        end
        return h;
    endfunction

endpackage

/* fib_stage_reg.sv */
`timescale 1ns/100ps

module fib_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Spare entry catches the beat accepted while out_ready was low
    logic     spare_valid;
    payload_t spare_data;
    logic     load_main;
    logic     load_spare;

    // Ready comes straight off a flop, low only when both entries are full
    assign in_ready = !spare_valid;

    // Main entry is free or draining this edge
    assign load_main  = out_ready || !out_valid;
    // Main stalled, park the incoming beat
    assign load_spare = !load_main && in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
        end else if (load_main) begin
            // Spare has priority, it is older than any input
            out_valid   <= spare_valid || in_valid;
            spare_valid <= 1'b0;
        end else if (load_spare) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_main) begin
            out_data <= spare_valid ? spare_data : in_data;
        end
        if (load_spare) begin
            spare_data <= in_data;
        end
    end

endmodule

/* fib_dispatch.sv */
`timescale 1ns/100ps
`include "fib_config.svh"

module fib_dispatch import fib_pkg::*; (
    input  logic          req_valid,
    input  fib_req_t      req,
    output fib_bank_req_t bank_req
);

    logic is_insert;
    logic is_lookup;

    // Only a valid request may touch the banks
    assign is_insert = req_valid && (req.op == FIB_OP_INSERT);
    assign is_lookup = req_valid && (req.op == FIB_OP_LOOKUP);

    always_comb begin
        // Sideband copied through for the selector
        bank_req.lookup = is_lookup;
        bank_req.prefix = req.prefix;
        bank_req.limit  = req.len;
        bank_req.wr_en  = '0;
        bank_req.rd_en  = '0;

        for (int k = 0; k < `FIB_NUM_LEN; k++) begin
            // Insert lands in exactly one bank
            if (is_insert && (int'(req.len) == k)) begin
                bank_req.wr_en[k] = 1'b1;
            end
            // Lookup probes every bank up to the limit
            if (is_lookup && (k <= int'(req.len))) begin
                bank_req.rd_en[k] = 1'b1;
            end
        end
    end

endmodule

/* fib_length_bank.sv */
`timescale 1ns/100ps
`include "fib_config.svh"

module fib_length_bank import fib_pkg::*; #(
    parameter int bank_len = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     advance,
    input  logic                     wr_en,
    input  logic                     rd_en,
    input  logic [`FIB_PREFIX_W-1:0] prefix,
    output logic                     hit
);

    // One valid bit per hash bucket for this prefix length
    logic [`FIB_BITMAP_DEPTH-1:0] bitmap;

    logic [`FIB_PREFIX_W-1:0] masked;
    logic [`FIB_HASH_W-1:0]   idx;

    // Length is fixed per bank so the mask is constant
    assign masked = fib_mask(prefix, `FIB_LEN_W'(bank_len));
    assign idx    = fib_hash(masked);

    // Set-only learning, entries never age out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bitmap <= '0;
        end else if (advance && wr_en) begin
            bitmap[idx] <= 1'b1;
        end
    end

    // Read result lines up with the sideband register in the top level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (advance) begin
            // Banks above the limit report low
            hit <= rd_en && bitmap[idx];
        end
    end

endmodule

/* fib_match_select.sv */
`timescale 1ns/100ps
`include "fib_config.svh"

module fib_match_select import fib_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lookup_valid,
    input  logic [`FIB_PREFIX_W-1:0] prefix,
    input  logic [`FIB_LEN_W-1:0]    limit,
    input  logic [`FIB_NUM_LEN-1:0]  hits,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output fib_resp_t                resp,
    output logic                     advance
);

    logic                  match_hit;
    logic [`FIB_LEN_W-1:0] match_len;
    fib_resp_t             resp_next;

    // Highest hitting bank wins, later iterations override
    always_comb begin
        match_hit = 1'b0;
        match_len = '0;
        for (int k = 0; k < `FIB_NUM_LEN; k++) begin
            // Limit also applied here, banks past it never count
            if (hits[k] && (k <= int'(limit))) begin
                match_hit = 1'b1;
                match_len = `FIB_LEN_W'(k);
            end
        end
    end

    // Miss gives length 0 and so a fully cleared prefix
    always_comb begin
        resp_next.hit    = match_hit;
        resp_next.len    = match_len;
        resp_next.prefix = fib_mask(prefix, match_len);
    end

    // Inserts are not pushed, they end here
    // The slice's ready is the advance for the whole pipeline
    fib_stage_reg #(
        .payload_t (fib_resp_t)
    ) u_out_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (lookup_valid),
        .in_ready  (advance),
        .in_data   (resp_next),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (resp)
    );

endmodule

/* fib_table_top.sv */
`timescale 1ns/100ps
`include "fib_config.svh"

module fib_table_top import fib_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  fib_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output fib_resp_t resp
);

    logic                     req_q_valid;
    fib_req_t                 req_q;
    fib_bank_req_t            bank_req;
    logic [`FIB_NUM_LEN-1:0]  hits;
    logic                     advance;

    // Sideband in step with the bank read register
    logic                     side_lookup;
    logic [`FIB_PREFIX_W-1:0] side_prefix;
    logic [`FIB_LEN_W-1:0]    side_limit;

    // Input slice pops only when the whole pipe moves
    fib_stage_reg #(
        .payload_t (fib_req_t)
    ) u_in_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (req_q_valid),
        .out_ready (advance),
        .out_data  (req_q)
    );

    fib_dispatch u_dispatch (
        .req_valid (req_q_valid),
        .req       (req_q),
        .bank_req  (bank_req)
    );

    // Bank k holds prefixes of length k
    for (genvar k = 0; k < `FIB_NUM_LEN; k++) begin : g_bank
        fib_length_bank #(
            .bank_len (k)
        ) u_bank (
            .clk     (clk),
            .rst     (rst),
            .advance (advance),
            .wr_en   (bank_req.wr_en[k]),
            .rd_en   (bank_req.rd_en[k]),
            .prefix  (bank_req.prefix),
            .hit     (hits[k])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            side_lookup <= 1'b0;
        end else if (advance) begin
            side_lookup <= bank_req.lookup;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            side_prefix <= bank_req.prefix;
            side_limit  <= bank_req.limit;
        end
    end

    fib_match_select u_select (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (side_lookup),
        .prefix       (side_prefix),
        .limit        (side_limit),
        .hits         (hits),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp         (resp),
        .advance      (advance)
    );

endmodule

/* fib_table_sva.sv */
`timescale 1ns/100ps

module fib_table_sva import fib_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      req_ready,
    input logic      resp_valid,
    input logic      resp_ready,
    input fib_resp_t resp
);

    // A stalled response holds until it is taken
    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("resp changed or dropped while resp_ready was low");

    // First edge out of reset sees an empty output slice
    resp_idle: assert property (@(posedge clk) $fell(rst) |-> !resp_valid)
        else $error("resp_valid high in the cycle after reset");

    // Input slice starts empty and open
    req_open: assert property (@(posedge clk) $fell(rst) |-> req_ready)
        else $error("req_ready low after reset");

endmodule

bind fib_table_top fib_table_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
);

/* tb_fib_table.sv */
`timescale 1ns/100ps
`include "fib_config.svh"

module tb_fib_table import fib_pkg::*; ();

    typedef logic [`FIB_PREFIX_W-1:0] prefix_t;

    localparam int NUM_MISS = 20;
    localparam int NUM_PAIR = 16;
    localparam int NUM_MIX  = 400;
    // Misses, pairs, nested set and both halves of the random mix
    localparam int NUM_REQ  = NUM_MISS + 2 * NUM_PAIR + 7 + 2 * NUM_MIX;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      req_valid = 1'b0;
    logic      req_ready;
    fib_req_t  req = '0;
    logic      resp_valid;
    logic      resp_ready = 1'b1;
    fib_resp_t resp;

    logic [31:0] stim_lfsr = 32'h1545;
    logic [31:0] ready_lfsr = 32'h1545;
    logic        ready_random = 1'b0;
    // Reference valid bits, one vector per prefix length
    logic [`FIB_BITMAP_DEPTH-1:0] model_bits [`FIB_NUM_LEN];
    fib_resp_t   exp_q [$];

    fib_table_top DUT (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp)
    );

    always #50 clk = ~clk;

    // Galois LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = stim_lfsr[0];
            stim_lfsr = lfsr_step(stim_lfsr);
        end
    endtask

    // Top len bits survive, length 0 clears everything
    function automatic prefix_t mask_to_len(input prefix_t p, input int len);
        return p & ({`FIB_PREFIX_W{1'b1}} << (`FIB_PREFIX_W - len));
    endfunction

    // Prefix bit i lands on hash bit i mod 10, short top chunk zero padded
    function automatic logic [`FIB_HASH_W-1:0] fold_to_index(input prefix_t p);
        logic [`FIB_HASH_W-1:0] h;
        h = '0;
        for (int i = 0; i < `FIB_PREFIX_W; i++) begin
            h[i % `FIB_HASH_W] = h[i % `FIB_HASH_W] ^ p[i];
        end
        return h;
    endfunction

    // Longest set length up to the limit, a miss answers length 0
    function automatic fib_resp_t expected_lookup(input prefix_t p, input int limit);
        fib_resp_t r;
        r = '0;
        for (int len = 0; len <= limit; len++) begin
            if (model_bits[len][fold_to_index(mask_to_len(p, len))]) begin
                r.hit = 1'b1;
                r.len = `FIB_LEN_W'(len);
            end
        end
        r.prefix = mask_to_len(p, int'(r.len));
        return r;
    endfunction

    // Starts just after a rising edge, returns just after the accepting edge
    task automatic send_req(input fib_op_e op, input prefix_t prefix, input int len);
        req_valid = 1'b1;
        req       = '{op: op, prefix: prefix, len: `FIB_LEN_W'(len)};
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        // Model follows acceptance order
        if (op == FIB_OP_INSERT) begin
            model_bits[len][fold_to_index(mask_to_len(prefix, len))] = 1'b1;
        end else begin
            exp_q.push_back(expected_lookup(prefix, len));
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     $time, name, got, want));
        end
    endtask

    // Both high at the falling edge means the next rising edge transfers
    always @(negedge clk) begin : compare
        fib_resp_t want;
        if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                report_failure("a response arrived with no lookup waiting for it");
            end
            want = exp_q.pop_front();
            check_value("resp.hit", 64'(resp.hit), 64'(want.hit));
            check_value("resp.len", 64'(resp.len), 64'(want.len));
            check_value("resp.prefix", resp.prefix, want.prefix);
        end
    end

    // Random stall pattern on the response side once enabled
    always @(posedge clk) begin
        #1;
        if (ready_random) begin
            resp_ready = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
        end else begin
            resp_ready = 1'b1;
        end
    end

    initial begin
        repeat (NUM_REQ * 20 + 200) @(posedge clk);
        report_failure("timeout, the test did not finish in the expected time");
    end

    initial begin
        logic [63:0] p;
        logic [63:0] v;
        foreach (model_bits[i]) begin
            model_bits[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Empty table, every lookup misses
        for (int i = 0; i < NUM_MISS; i++) begin
            draw_bits(64, p);
            draw_bits(6, v);
            send_req(FIB_OP_LOOKUP, p, int'(v[5:0]));
        end

        // Nested lengths, the limits pick 40, 24, 8 and a miss
        draw_bits(64, p);
        send_req(FIB_OP_INSERT, p, 8);
        send_req(FIB_OP_INSERT, p, 24);
        send_req(FIB_OP_INSERT, p, 40);
        send_req(FIB_OP_LOOKUP, p, 63);
        send_req(FIB_OP_LOOKUP, p, 30);
        send_req(FIB_OP_LOOKUP, p, 20);
        send_req(FIB_OP_LOOKUP, p, 5);

        // Insert, then look up with its own length as limit
        for (int i = 0; i < NUM_PAIR; i++) begin
            draw_bits(64, p);
            draw_bits(6, v);
            send_req(FIB_OP_INSERT, p, int'(v[5:0]));
            send_req(FIB_OP_LOOKUP, p, int'(v[5:0]));
        end

        // Random mix, second half with stalls on resp_ready and idle gaps
        p = '0;
        for (int i = 0; i < 2 * NUM_MIX; i++) begin
            ready_random = (i >= NUM_MIX);
            draw_bits(9, v);
            // Keep the last prefix half the time so lookups find entries
            if (v[0]) begin
                draw_bits(64, p);
            end
            send_req(fib_op_e'(v[1]), p, int'(v[7:2]));
            if (ready_random && v[8]) begin
                @(posedge clk);
                #1;
            end
        end

        // Drain, then watch a little longer for stray responses
        for (int i = 0; i < 200 && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("some lookups never got a response");
        end
    end

endmodule

/* fib_table.f */
+incdir+.
fib_pkg.sv
fib_stage_reg.sv
fib_dispatch.sv
fib_length_bank.sv
fib_match_select.sv
fib_table_top.sv
fib_table_sva.sv
tb_fib_table.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the FIB table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fib_table \
    -f fib_table.f -o tb_fib_table > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_fib_table > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
